/* wl_top.f */
logic/wl_pkg.sv
logic/route_queue.sv
logic/data_demux.sv
logic/mem_arbiter.sv
logic/data_mem.sv
logic/wl_csrs.sv
logic/wl_top.sv
test/tb_wl_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the wl_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f wl_top.f --top-module tb_wl_top
./obj_dir/Vtb_wl_top > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* test/wl_stimulus.txt */
// port (1 core, 2 bus, 3 core with next bus line) write strb addr data
// expected data, expected error, expected eoc (core lines only)
1_1_f_00010010_11223344_00000000_0_00000000
1_0_f_00010010_00000000_11223344_0_00000000
1_1_5_00010010_aabbccdd_00000000_0_00000000
1_0_f_00010010_00000000_11bb33dd_0_00000000
2_1_f_dead0020_cafef00d_00000000_0_00000000
1_0_f_00010020_00000000_cafef00d_0_00000000
2_0_f_ffff0010_00000000_11bb33dd_0_00000000
1_1_f_00020000_000000c0_00000000_0_000000c0
1_0_f_00020000_00000000_000000c0_0_000000c0
1_1_f_00020004_11112222_00000000_0_000000c0
1_0_f_00020004_00000000_11112222_0_000000c0
1_1_f_00020010_ffffffff_00000000_1_000000c0
1_0_f_000200fc_00000000_00000000_1_000000c0
1_1_3_80000004_55667788_25a50004_0_000000c0
1_0_f_30000040_00000000_95a50040_0_000000c0
3_1_f_00010100_0badf00d_00000000_0_000000c0
2_1_f_12340104_feedbeef_00000000_0_00000000
3_0_f_00010104_00000000_feedbeef_0_000000c0
2_0_f_00000100_00000000_0badf00d_0_00000000
1_0_f_00010100_00000000_0badf00d_0_000000c0

/* test/tb_wl_top.sv */
////////////////////////////////////////
// Testbench for the core-side data path
// Plays core, bus master and external target from the
// stimulus file and checks every response in order
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_wl_top
  import wl_pkg::*;
;

  localparam int unsigned MaxLines = 64;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  data_req_t            core_req;
  data_rsp_t            core_rsp;
  data_req_t            bus_req;
  data_rsp_t            bus_rsp;
  data_req_t            ext_req;
  data_rsp_t            ext_rsp;
  logic [DataWidth-1:0] eoc;

  // Columns: port, write, strb, addr, data, exp data, exp error, exp eoc
  logic [143:0] stim [MaxLines];
  data_req_t    exp_ext_req;
  int           num_lines = 0;
  int           limit_cycles = 0;
  int           cycle = 0;
  int           mismatch_errors = 0;
  int           other_errors = 0;
  int           core_done = 0;
  int           bus_done = 0;
  int unsigned  seed_val;

  wl_top i_dut (
    .clk_i      ( clk_i    ),
    .reset_i    ( reset_i  ),
    .core_req_i ( core_req ),
    .core_rsp_o ( core_rsp ),
    .bus_req_i  ( bus_req  ),
    .bus_rsp_o  ( bus_rsp  ),
    .ext_req_o  ( ext_req  ),
    .ext_rsp_i  ( ext_rsp  ),
    .eoc_o      ( eoc      )
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  // Random response-ready back-pressure on both requesters
  initial begin : backpressure
    seed_val = $urandom(32'h9f6b);
    forever begin
      @(negedge clk_i);
      core_req.p_ready = ($urandom % 4) != 0;
      bus_req.p_ready  = ($urandom % 4) != 0;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input data_rsp_t got, input data_rsp_t exp, input string what);
    if (got.data !== exp.data || got.error !== exp.error) begin
      mismatch_errors++;
      $display("mismatch at %0t: %s response data %h error %b, expected data %h error %b",
               $time, what, got.data, got.error, exp.data, exp.error);
    end
  endtask

  task automatic check_req(input data_req_t got, input data_req_t exp);
    if (got.addr !== exp.addr || got.write !== exp.write ||
        got.data !== exp.data || got.strb !== exp.strb) begin
      mismatch_errors++;
      $display("mismatch at %0t: external request %h/%b/%h/%h, expected %h/%b/%h/%h",
               $time, got.addr, got.write, got.data, got.strb,
               exp.addr, exp.write, exp.data, exp.strb);
    end
  endtask

  task automatic check_eoc(input logic [DataWidth-1:0] got, input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("mismatch at %0t: eoc_o %h, expected %h", $time, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Requester tasks
  ////////////////////////////////////////

  task automatic run_core(input logic [143:0] line);
    data_rsp_t exp;
    exp = '0;
    exp.data  = line[67:36];
    exp.error = line[32];
    @(negedge clk_i);
    core_req.addr    = line[131:100];
    core_req.write   = line[136];
    core_req.strb    = line[135:132];
    core_req.data    = line[99:68];
    core_req.q_valid = 1'b1;
    exp_ext_req = core_req;
    @(posedge clk_i);
    while (!core_rsp.q_ready) @(posedge clk_i);
    @(negedge clk_i);
    core_req.q_valid = 1'b0;
    @(posedge clk_i);
    while (!(core_rsp.p_valid && core_req.p_ready)) @(posedge clk_i);
    check_rsp(core_rsp, exp, "core");
    check_eoc(eoc, line[31:0]);
    core_done = cycle;
  endtask

  task automatic run_bus(input logic [143:0] line);
    data_rsp_t exp;
    exp = '0;
    exp.data  = line[67:36];
    exp.error = line[32];
    @(negedge clk_i);
    bus_req.addr    = line[131:100];
    bus_req.write   = line[136];
    bus_req.strb    = line[135:132];
    bus_req.data    = line[99:68];
    bus_req.q_valid = 1'b1;
    @(posedge clk_i);
    while (!bus_rsp.q_ready) @(posedge clk_i);
    @(negedge clk_i);
    bus_req.q_valid = 1'b0;
    @(posedge clk_i);
    while (!(bus_rsp.p_valid && bus_req.p_ready)) @(posedge clk_i);
    check_rsp(bus_rsp, exp, "bus");
    bus_done = cycle;
  endtask

  // External target, answers one cycle after accept
  always begin : ext_target
    logic                 accepted;
    logic                 taken;
    logic [DataWidth-1:0] rdata;
    @(posedge clk_i);
    accepted = !reset_i && ext_req.q_valid && ext_rsp.q_ready;
    taken    = !reset_i && ext_rsp.p_valid && ext_req.p_ready;
    if (accepted) begin
      check_req(ext_req, exp_ext_req);
      rdata = ext_req.addr ^ 32'hA5A5_0000;
    end
    @(negedge clk_i);
    if (accepted) begin
      ext_rsp.p_valid = 1'b1;
      ext_rsp.q_ready = 1'b0;
      ext_rsp.data    = rdata;
    end else if (taken) begin
      ext_rsp.p_valid = 1'b0;
      ext_rsp.q_ready = 1'b1;
    end
  end

  task automatic close_run();
    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin : watchdog
    wait (limit_cycles != 0);
    while (cycle <= limit_cycles) @(posedge clk_i);
    $display("timeout: transactions did not finish within %0d cycles", limit_cycles);
    other_errors++;
    close_run();
  end

  initial begin : main
    int idx;
    reset_i  = 1'b1;
    core_req = '0;
    bus_req  = '0;
    ext_rsp  = '0;
    ext_rsp.q_ready = 1'b1;
    for (int i = 0; i < MaxLines; i++) begin
      stim[i] = '0;
    end
    $readmemh("test/wl_stimulus.txt", stim);
    while (num_lines < MaxLines && stim[num_lines][143:140] != 4'h0) num_lines++;
    limit_cycles = num_lines * 30 + 200;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    idx = 0;
    while (idx < num_lines) begin
      if (stim[idx][143:140] == 4'h3 && idx + 1 < num_lines) begin
        // Core and bus present in the same cycle
        fork
          run_core(stim[idx]);
          run_bus(stim[idx + 1]);
        join
        if (core_done >= bus_done) begin
          other_errors++;
          $display("bus response came before the core response at line %0d", idx);
        end
        idx += 2;
      end else if (stim[idx][143:140] == 4'h1) begin
        run_core(stim[idx]);
        idx++;
      end else begin
        run_bus(stim[idx]);
        idx++;
      end
    end
    close_run();
  end

endmodule

`default_nettype wire

/* logic/wl_top.sv */
////////////////////////////////////////
// Core-side data path top level
// Core port decoded to memory, registers or external;
// bus port shares the data memory through the arbiter
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module wl_top
  import wl_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  data_req_t             core_req_i,
  output data_rsp_t             core_rsp_o,
  input  data_req_t             bus_req_i,
  output data_rsp_t             bus_rsp_o,
  output data_req_t             ext_req_o,
  input  data_rsp_t             ext_rsp_i,
  output logic [DataWidth-1:0]  eoc_o
);

  // Decoder to arbiter, decoder to registers, arbiter to memory
  data_req_t demux_mem_req;
  data_rsp_t demux_mem_rsp;
  data_req_t csr_req;
  data_rsp_t csr_rsp;
  data_req_t mem_req;
  data_rsp_t mem_rsp;

  data_demux i_data_demux (
    .clk_i      ( clk_i         ),
    .reset_i    ( reset_i       ),
    .core_req_i ( core_req_i    ),
    .core_rsp_o ( core_rsp_o    ),
    .mem_req_o  ( demux_mem_req ),
    .mem_rsp_i  ( demux_mem_rsp ),
    .csr_req_o  ( csr_req       ),
    .csr_rsp_i  ( csr_rsp       ),
    .ext_req_o  ( ext_req_o     ),
    .ext_rsp_i  ( ext_rsp_i     )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i      ( clk_i         ),
    .reset_i    ( reset_i       ),
    .core_req_i ( demux_mem_req ),
    .core_rsp_o ( demux_mem_rsp ),
    .bus_req_i  ( bus_req_i     ),
    .bus_rsp_o  ( bus_rsp_o     ),
    .mem_req_o  ( mem_req       ),
    .mem_rsp_i  ( mem_rsp       )
  );

  data_mem i_data_mem (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .req_i   ( mem_req ),
    .rsp_o   ( mem_rsp )
  );

  wl_csrs i_csrs (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .req_i   ( csr_req ),
    .rsp_o   ( csr_rsp ),
    .eoc_o   ( eoc_o   )
  );

endmodule

`default_nettype wire

/* logic/wl_csrs.sv */
////////////////////////////////////////
// Control register file
// Register 0 drives the end-of-computation value;
// out-of-range indices answer with an error
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module wl_csrs
  import wl_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   reset_i,
  input  data_req_t             req_i,
  output data_rsp_t             rsp_o,
  output logic [DataWidth-1:0]  eoc_o
);

  localparam int unsigned ByteOffset = $clog2(StrbWidth);
  localparam int unsigned RegIdxWidth = $clog2(CsrOffset / StrbWidth);
  localparam int unsigned SelWidth = $clog2(CsrNumRegs);
  localparam logic [AddrWidth-1:0] CsrMask = ~(CsrOffset - 32'd1);

  logic [DataWidth-1:0]   regs_q [CsrNumRegs];
  logic [RegIdxWidth-1:0] reg_idx;
  logic [SelWidth-1:0]    reg_sel;
  logic                   idx_valid;
  logic                   accept;
  logic                   rsp_valid_q;
  logic [DataWidth-1:0]   rsp_data_q;
  logic                   rsp_error_q;

  assign reg_idx   = req_i.addr[ByteOffset +: RegIdxWidth];
  assign reg_sel   = reg_idx[SelWidth-1:0];
  assign idx_valid = (reg_idx < RegIdxWidth'(CsrNumRegs));
  assign accept    = req_i.q_valid && rsp_o.q_ready;

  assign rsp_o.q_ready = !rsp_valid_q || req_i.p_ready;
  assign rsp_o.p_valid = rsp_valid_q;
  assign rsp_o.data    = rsp_data_q;
  assign rsp_o.error   = rsp_error_q;
  assign eoc_o         = regs_q[0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
      for (int r = 0; r < CsrNumRegs; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      if (accept) begin
        rsp_valid_q <= 1'b1;
      end else if (req_i.p_ready) begin
        rsp_valid_q <= 1'b0;
      end
      // Bad index leaves the registers untouched
      if (accept && req_i.write && idx_valid) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (req_i.strb[b]) begin
            regs_q[reg_sel][b*8 +: 8] <= req_i.data[b*8 +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_error_q <= !idx_valid;
      rsp_data_q  <= (idx_valid && !req_i.write) ? regs_q[reg_sel] : '0;
    end
  end

  // Decoder must only route the register window here
  in_csr_window: assert property (
    @(posedge clk_i) disable iff (reset_i)
    req_i.q_valid |-> ((req_i.addr & CsrMask) == CsrBaseAddr)
  ) else $error("register request outside its window");

endmodule

`default_nettype wire

/* logic/data_mem.sv */
////////////////////////////////////////
// Single-port data memory
// Byte-strobed writes, registered read data one cycle
// after the request is taken
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module data_mem
  import wl_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  data_req_t req_i,
  output data_rsp_t rsp_o
);

  localparam int unsigned ByteOffset = $clog2(StrbWidth);

  logic [DataWidth-1:0]        mem_q [DataMemWords];
  logic [DataMemAddrWidth-1:0] word_idx;
  logic                        rsp_valid_q;
  logic [DataWidth-1:0]        rsp_data_q;
  logic                        accept;

  assign word_idx = req_i.addr[ByteOffset +: DataMemAddrWidth];
  // New request only when the held response is gone or leaving
  assign accept = req_i.q_valid && rsp_o.q_ready;

  assign rsp_o.q_ready = !rsp_valid_q || req_i.p_ready;
  assign rsp_o.p_valid = rsp_valid_q;
  assign rsp_o.data    = rsp_data_q;
  assign rsp_o.error   = 1'b0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (req_i.p_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.write) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (req_i.strb[b]) begin
            mem_q[word_idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
          end
        end
        rsp_data_q <= '0;
      end else begin
        rsp_data_q <= mem_q[word_idx];
      end
    end
  end

  // The arbiter hands over offsets, never full addresses
  offset_in_range: assert property (
    @(posedge clk_i) disable iff (reset_i) req_i.q_valid |-> (req_i.addr < DataMemOffset)
  ) else $error("data memory address not remapped");

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
////////////////////////////////////////
// Data memory arbiter
// Shares the memory between core and bus port, core first,
// and steers each response back to its owner
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
  import wl_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  data_req_t core_req_i,
  output data_rsp_t core_rsp_o,
  input  data_req_t bus_req_i,
  output data_rsp_t bus_rsp_o,
  output data_req_t mem_req_o,
  input  data_rsp_t mem_rsp_i
);

  localparam logic [AddrWidth-1:0] OffsetMask = DataMemOffset - 32'd1;

  arb_idx_t grant_idx;
  arb_idx_t head;
  logic     q_empty;
  logic     q_full;
  logic     push;
  logic     pop;
  logic     owner_p_ready;

  // Fixed priority, the bus only wins when the core is idle
  assign grant_idx = core_req_i.q_valid ? ArbCore : ArbBus;
  assign owner_p_ready = (head == ArbCore) ? core_req_i.p_ready : bus_req_i.p_ready;

  always_comb begin
    mem_req_o = (grant_idx == ArbCore) ? core_req_i : bus_req_i;
    // Strip the window base so the memory sees a plain offset
    mem_req_o.addr    = mem_req_o.addr & OffsetMask;
    mem_req_o.q_valid = (core_req_i.q_valid || bus_req_i.q_valid) && !q_full;
    mem_req_o.p_ready = owner_p_ready && !q_empty;
  end

  always_comb begin
    core_rsp_o.q_ready = mem_rsp_i.q_ready && !q_full;
    core_rsp_o.p_valid = mem_rsp_i.p_valid && !q_empty && (head == ArbCore);
    core_rsp_o.data    = mem_rsp_i.data;
    core_rsp_o.error   = mem_rsp_i.error;
    bus_rsp_o.q_ready  = mem_rsp_i.q_ready && !q_full && !core_req_i.q_valid;
    bus_rsp_o.p_valid  = mem_rsp_i.p_valid && !q_empty && (head == ArbBus);
    bus_rsp_o.data     = mem_rsp_i.data;
    bus_rsp_o.error    = mem_rsp_i.error;
  end

  assign push = mem_req_o.q_valid && mem_rsp_i.q_ready;
  assign pop  = mem_rsp_i.p_valid && mem_req_o.p_ready;

  route_queue #(
    .idx_t ( arb_idx_t  ),
    .Depth ( RouteDepth )
  ) i_route_queue (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .push_i  ( push      ),
    .idx_i   ( grant_idx ),
    .pop_i   ( pop       ),
    .idx_o   ( head      ),
    .empty_o ( q_empty   ),
    .full_o  ( q_full    )
  );

  // Every memory response goes back to exactly one granted owner
  one_owner_per_rsp: assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_rsp_i.p_valid |-> $onehot({core_rsp_o.p_valid, bus_rsp_o.p_valid})
  ) else $error("memory response without exactly one owner");

endmodule

`default_nettype wire

/* logic/data_demux.sv */
////////////////////////////////////////
// Core data port decoder
// Routes each request to memory, registers or the external
// port by base/mask match and returns responses in order
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module data_demux
  import wl_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  data_req_t core_req_i,
  output data_rsp_t core_rsp_o,
  output data_req_t mem_req_o,
  input  data_rsp_t mem_rsp_i,
  output data_req_t csr_req_o,
  input  data_rsp_t csr_rsp_i,
  output data_req_t ext_req_o,
  input  data_rsp_t ext_rsp_i
);

  localparam logic [AddrWidth-1:0] MemMask = ~(DataMemOffset - 32'd1);
  localparam logic [AddrWidth-1:0] CsrMask = ~(CsrOffset - 32'd1);

  demux_idx_t sel;
  demux_idx_t head;
  logic       tgt_ready;
  logic       q_empty;
  logic       q_full;
  logic       push;
  logic       pop;
  data_rsp_t  head_rsp;

  ////////////////////////////////////////
  // Request path
  ////////////////////////////////////////

  // Anything outside both windows falls through to external
  always_comb begin
    if ((core_req_i.addr & MemMask) == DataMemBaseAddr) begin
      sel = DemuxMem;
    end else if ((core_req_i.addr & CsrMask) == CsrBaseAddr) begin
      sel = DemuxCsr;
    end else begin
      sel = DemuxExt;
    end
  end

  always_comb begin
    case (sel)
      DemuxMem: tgt_ready = mem_rsp_i.q_ready;
      DemuxCsr: tgt_ready = csr_rsp_i.q_ready;
      default:  tgt_ready = ext_rsp_i.q_ready;
    endcase
  end

  // Valid only reaches a target when the route can be recorded
  always_comb begin
    mem_req_o = core_req_i;
    csr_req_o = core_req_i;
    ext_req_o = core_req_i;
    mem_req_o.q_valid = core_req_i.q_valid && !q_full && (sel == DemuxMem);
    csr_req_o.q_valid = core_req_i.q_valid && !q_full && (sel == DemuxCsr);
    ext_req_o.q_valid = core_req_i.q_valid && !q_full && (sel == DemuxExt);
    mem_req_o.p_ready = core_req_i.p_ready && !q_empty && (head == DemuxMem);
    csr_req_o.p_ready = core_req_i.p_ready && !q_empty && (head == DemuxCsr);
    ext_req_o.p_ready = core_req_i.p_ready && !q_empty && (head == DemuxExt);
  end

  ////////////////////////////////////////
  // Response path
  ////////////////////////////////////////

  always_comb begin
    case (head)
      DemuxMem: head_rsp = mem_rsp_i;
      DemuxCsr: head_rsp = csr_rsp_i;
      default:  head_rsp = ext_rsp_i;
    endcase
  end

  always_comb begin
    core_rsp_o.q_ready = !q_full && tgt_ready;
    core_rsp_o.p_valid = !q_empty && head_rsp.p_valid;
    core_rsp_o.data    = head_rsp.data;
    core_rsp_o.error   = head_rsp.error;
  end

  assign push = core_req_i.q_valid && core_rsp_o.q_ready;
  assign pop  = core_rsp_o.p_valid && core_req_i.p_ready;

  route_queue #(
    .idx_t ( demux_idx_t ),
    .Depth ( RouteDepth  )
  ) i_route_queue (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .push_i  ( push    ),
    .idx_i   ( sel     ),
    .pop_i   ( pop     ),
    .idx_o   ( head    ),
    .empty_o ( q_empty ),
    .full_o  ( q_full  )
  );

  // Targets only answer requests that were routed to them
  rsp_without_route: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mem_rsp_i.p_valid || csr_rsp_i.p_valid || ext_rsp_i.p_valid) |-> !q_empty
  ) else $error("target response with empty route queue");

endmodule

`default_nettype wire

/* logic/route_queue.sv */
////////////////////////////////////////
// In-order FIFO of route indices
// Push on request accept, pop on response transfer;
// the head tells which port owes the next response
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module route_queue
  import wl_pkg::*;
#(
  parameter type         idx_t = logic [1:0],
  parameter int unsigned Depth = RouteDepth
) (
  input  wire  clk_i,
  input  wire  reset_i,
  input  logic push_i,
  input  idx_t idx_i,
  input  logic pop_i,
  output idx_t idx_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  idx_t                slots_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));
  assign idx_o   = slots_q[rd_ptr_q];

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slots_q[wr_ptr_q] <= idx_i;
    end
  end

  // Users must gate their handshakes with full/empty
  push_while_full: assert property (
    @(posedge clk_i) disable iff (reset_i) !(push_i && full_o)
  ) else $error("route queue pushed while full");

  pop_while_empty: assert property (
    @(posedge clk_i) disable iff (reset_i) !(pop_i && empty_o)
  ) else $error("route queue popped while empty");

endmodule

`default_nettype wire

/* logic/wl_pkg.sv */
////////////////////////////////////////
// Shared definitions for the core data path
// Address map, bus widths, route index types and the
// request/response structs used on every port pair
////////////////////////////////////////

`default_nettype none

package wl_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////

  // Data memory window, naturally aligned
  localparam logic [AddrWidth-1:0] DataMemBaseAddr = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] DataMemOffset = 32'h0000_1000;
  localparam int unsigned DataMemWords = 1024;
  localparam int unsigned DataMemAddrWidth = 10;

  // Register file window
  localparam logic [AddrWidth-1:0] CsrBaseAddr = 32'h0002_0000;
  localparam logic [AddrWidth-1:0] CsrOffset = 32'h0000_0100;
  localparam int unsigned CsrNumRegs = 4;

  // Two requests in flight per route queue
  localparam int unsigned RouteDepth = 2;

  ////////////////////////////////////////
  // Route indices and port structs
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    DemuxMem = 2'd0,
    DemuxCsr = 2'd1,
    DemuxExt = 2'd2
  } demux_idx_t;

  typedef enum logic {
    ArbCore = 1'b0,
    ArbBus  = 1'b1
  } arb_idx_t;

  // Request side, driven toward the target
  typedef struct packed {
    logic                 q_valid;
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 p_ready;
  } data_req_t;

  // Response side, driven back by the target
  typedef struct packed {
    logic                 q_ready;
    logic                 p_valid;
    logic [DataWidth-1:0] data;
    logic                 error;
  } data_rsp_t;

endpackage

`default_nettype wire
